// ==== Makefile ====
# Verilator build and run of the receive chain testbench
VERILATOR ?= verilator
TOP       ?= tb_receive_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timescale 1ns/1ns
PASS_MSG  ?= No errors

.PHONY: sim clean

# pass only if the log holds the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== channel_mux.sv ====
`timescale 1ns/1ns
// selects raw or differentiated input per logical channel
// raw path delayed one cycle to line up with the differentiator
module channel_mux (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic [rx_pkg::CHANNELS-1:0][rx_pkg::WORD_WIDTH-1:0] raw_data,
  input  logic [rx_pkg::CHANNELS-1:0]                         raw_valid,
  input  logic [rx_pkg::CHANNELS-1:0][rx_pkg::WORD_WIDTH-1:0] diff_data,
  input  logic [rx_pkg::CHANNELS-1:0]                         diff_valid,
  input  logic [rx_pkg::CHANNELS-1:0][rx_pkg::SEL_WIDTH-1:0]  config_data,
  input  logic                                                config_valid,
  output logic [rx_pkg::CHANNELS-1:0][rx_pkg::WORD_WIDTH-1:0] mux_data,
  output logic [rx_pkg::CHANNELS-1:0]                         mux_valid
);

  logic [rx_pkg::CHANNELS-1:0][rx_pkg::SEL_WIDTH-1:0]    sel;  // one field per logical channel
  logic [rx_pkg::CHANNELS-1:0][rx_pkg::WORD_WIDTH-1:0]   raw_data_d;
  logic [rx_pkg::CHANNELS-1:0]                           raw_valid_d;
  logic [rx_pkg::MUX_INPUTS-1:0][rx_pkg::WORD_WIDTH-1:0] in_data;  // all candidate inputs
  logic [rx_pkg::MUX_INPUTS-1:0]                         in_valid;

  // raw on the low codes and differentiated from SEL_DIFF_BASE up
  always_comb begin
    for (int c = 0; c < rx_pkg::CHANNELS; c++) begin
      in_data[c]                          = raw_data_d[c];
      in_valid[c]                         = raw_valid_d[c];
      in_data[rx_pkg::SEL_DIFF_BASE + c]  = diff_data[c];
      in_valid[rx_pkg::SEL_DIFF_BASE + c] = diff_valid[c];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int c = 0; c < rx_pkg::CHANNELS; c++) begin
        sel[c] <= c[rx_pkg::SEL_WIDTH-1:0];  // raw c feeds logical c
      end
      raw_valid_d <= '0;
      mux_valid   <= '0;
    end else begin
      if (config_valid) sel <= config_data;  // realtime config word
      raw_valid_d <= raw_valid;
      for (int c = 0; c < rx_pkg::CHANNELS; c++) begin
        mux_valid[c] <= in_valid[sel[c]];
      end
    end
  end

  // raw delay and selected payload
  always_ff @(posedge clk) begin
    raw_data_d <= raw_data;
    for (int c = 0; c < rx_pkg::CHANNELS; c++) begin
      mux_data[c] <= in_data[sel[c]];
    end
  end

endmodule

// ==== files.f ====
+incdir+.
rx_pkg.sv
sample_differentiator.sv
channel_mux.sv
sample_discriminator.sv
sample_buffer.sv
receive_top.sv
tb_receive_top.sv

// ==== receive_top.sv ====
`timescale 1ns/1ns
// receive chain top: differentiators, channel mux, discriminator, buffer
// decodes the buffer command word into start / stop pulses
module receive_top (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic [rx_pkg::CHANNELS-1:0][rx_pkg::WORD_WIDTH-1:0]   adc_data,
  input  logic [rx_pkg::CHANNELS-1:0]                           adc_valid,
  input  logic [rx_pkg::CHANNELS-1:0][rx_pkg::SEL_WIDTH-1:0]    mux_config_data,
  input  logic                                                  mux_config_valid,
  input  logic [rx_pkg::CHANNELS-1:0][rx_pkg::SAMPLE_WIDTH-1:0] disc_config_data,
  input  logic                                                  disc_config_valid,
  input  logic [1:0]                                            buffer_config_data,  // stop, start
  input  logic                                                  buffer_config_valid,
  output logic [rx_pkg::WORD_WIDTH-1:0]                         dma_data,
  output logic                                                  dma_valid,
  input  logic                                                  dma_ready,
  output logic                                                  dma_last
);

  logic [rx_pkg::CHANNELS-1:0][rx_pkg::WORD_WIDTH-1:0]   diff_data;
  logic [rx_pkg::CHANNELS-1:0]                           diff_valid;
  logic [rx_pkg::CHANNELS-1:0][rx_pkg::WORD_WIDTH-1:0]   mux_data;   // logical channels
  logic [rx_pkg::CHANNELS-1:0]                           mux_valid;
  logic [rx_pkg::CHANNELS-1:0][rx_pkg::WORD_WIDTH-1:0]   disc_data;
  logic [rx_pkg::CHANNELS-1:0]                           disc_valid;
  logic [rx_pkg::CHANNELS-1:0]                           disc_keep;
  logic [rx_pkg::CHANNELS-1:0][rx_pkg::TSTAMP_WIDTH-1:0] disc_tstamp;
  logic                                                  start;
  logic                                                  stop;

  // single-cycle command pulses
  assign start = buffer_config_valid && buffer_config_data[rx_pkg::CMD_START];
  assign stop  = buffer_config_valid && buffer_config_data[rx_pkg::CMD_STOP];

  // one differentiator per physical channel, no back-pressure
  for (genvar ch = 0; ch < rx_pkg::CHANNELS; ch++) begin : g_diff
    sample_differentiator diff_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .data       (adc_data[ch]),
      .valid      (adc_valid[ch]),
      .diff_data  (diff_data[ch]),
      .diff_valid (diff_valid[ch])
    );
  end

  channel_mux mux_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .raw_data     (adc_data),
    .raw_valid    (adc_valid),
    .diff_data    (diff_data),
    .diff_valid   (diff_valid),
    .config_data  (mux_config_data),
    .config_valid (mux_config_valid),
    .mux_data     (mux_data),
    .mux_valid    (mux_valid)
  );

  sample_discriminator disc_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .data         (mux_data),
    .valid        (mux_valid),
    .config_data  (disc_config_data),
    .config_valid (disc_config_valid),
    .start        (start),  // timestamps restart with capture
    .disc_data    (disc_data),
    .disc_valid   (disc_valid),
    .disc_keep    (disc_keep),
    .disc_tstamp  (disc_tstamp)
  );

  sample_buffer buffer_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .disc_data   (disc_data),
    .disc_valid  (disc_valid),
    .disc_keep   (disc_keep),
    .disc_tstamp (disc_tstamp),
    .start       (start),
    .stop        (stop),
    .dma_data    (dma_data),
    .dma_valid   (dma_valid),
    .dma_ready   (dma_ready),
    .dma_last    (dma_last)
  );

endmodule

// ==== rx_pkg.sv ====
// widths, depths and mux select codes for the receive chain
// plus bit positions of the buffer command word
package rx_pkg;

  // channel layout
  localparam int CHANNELS = 2;          // physical and logical channels alike
  localparam int PARALLEL_SAMPLES = 2;  // samples per word
  localparam int SAMPLE_WIDTH = 16;     // signed, two's complement
  localparam int WORD_WIDTH = PARALLEL_SAMPLES * SAMPLE_WIDTH;

  // mux inputs are raw channels first, then differentiated ones
  localparam int MUX_INPUTS = 2 * CHANNELS;
  localparam int SEL_WIDTH = $clog2(MUX_INPUTS);
  localparam int SEL_DIFF_BASE = CHANNELS;  // select code of diff channel 0

  // timestamp is a per-channel word counter
  localparam int TSTAMP_WIDTH = 32;

  // per-channel sample / timestamp memories
  localparam int BUFFER_DEPTH = 64;
  localparam int ADDR_WIDTH = $clog2(BUFFER_DEPTH);

  // buffer command word
  localparam int CMD_START = 0;  // clear buffers, begin capture
  localparam int CMD_STOP = 1;   // end capture, begin readout

endpackage

// ==== sample_buffer.sv ====
`timescale 1ns/1ns
// per-channel sample and timestamp memories with capture control
// readout FSM streams count, then timestamp/data pairs, per channel
module sample_buffer (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic [rx_pkg::CHANNELS-1:0][rx_pkg::WORD_WIDTH-1:0]   disc_data,
  input  logic [rx_pkg::CHANNELS-1:0]                           disc_valid,
  input  logic [rx_pkg::CHANNELS-1:0]                           disc_keep,
  input  logic [rx_pkg::CHANNELS-1:0][rx_pkg::TSTAMP_WIDTH-1:0] disc_tstamp,
  input  logic                                                  start,
  input  logic                                                  stop,
  output logic [rx_pkg::WORD_WIDTH-1:0]                         dma_data,
  output logic                                                  dma_valid,
  input  logic                                                  dma_ready,
  output logic                                                  dma_last
);

  typedef enum logic [1:0] {
    S_IDLE,    // capturing or waiting for start
    S_COUNT,   // entry count of rd_ch
    S_TSTAMP,  // timestamp of entry rd_idx
    S_DATA     // data of entry rd_idx
  } state_t;

  logic [rx_pkg::WORD_WIDTH-1:0]   data_mem   [rx_pkg::CHANNELS][rx_pkg::BUFFER_DEPTH];
  logic [rx_pkg::TSTAMP_WIDTH-1:0] tstamp_mem [rx_pkg::CHANNELS][rx_pkg::BUFFER_DEPTH];

  logic [rx_pkg::CHANNELS-1:0][rx_pkg::ADDR_WIDTH:0] wr_count;  // entries, 0..DEPTH
  logic [rx_pkg::CHANNELS-1:0]                       wr_en;
  logic                                              capture;
  logic                                              read_done;  // blocks re-read until start
  state_t                                            state;
  logic [$clog2(rx_pkg::CHANNELS)-1:0]               rd_ch;
  logic [rx_pkg::ADDR_WIDTH-1:0]                     rd_idx;
  logic [rx_pkg::WORD_WIDTH-1:0]                     rd_word;   // next word to present
  logic                                              last_ch;
  logic                                              rd_end_ch;  // word closes its channel
  logic                                              rd_last;
  logic                                              load;       // output register takes rd_word

  always_comb begin
    for (int c = 0; c < rx_pkg::CHANNELS; c++) begin
      // full channel drops words until next start
      wr_en[c] = capture && disc_valid[c] && disc_keep[c] &&
                 (wr_count[c] != rx_pkg::BUFFER_DEPTH);
    end
    last_ch = (rd_ch == rx_pkg::CHANNELS - 1);
    if (state == S_COUNT) begin
      rd_end_ch = (wr_count[rd_ch] == '0);  // empty channel, count only
    end else begin
      rd_end_ch = ({1'b0, rd_idx} == wr_count[rd_ch] - 1'b1);
    end
    rd_last = last_ch && rd_end_ch && (state != S_TSTAMP);
    case (state)
      S_COUNT:  rd_word = {{(rx_pkg::WORD_WIDTH-rx_pkg::ADDR_WIDTH-1){1'b0}}, wr_count[rd_ch]};
      S_TSTAMP: rd_word = tstamp_mem[rd_ch][rd_idx];
      default:  rd_word = data_mem[rd_ch][rd_idx];
    endcase
    load = (state != S_IDLE) && (!dma_valid || dma_ready);
  end

  // memories, written in arrival order
  always_ff @(posedge clk) begin
    for (int c = 0; c < rx_pkg::CHANNELS; c++) begin
      if (wr_en[c]) begin
        data_mem[c][wr_count[c][rx_pkg::ADDR_WIDTH-1:0]]   <= disc_data[c];
        tstamp_mem[c][wr_count[c][rx_pkg::ADDR_WIDTH-1:0]] <= disc_tstamp[c];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      capture   <= 1'b0;
      read_done <= 1'b0;  // stop right after reset reads empty buffers
      state     <= S_IDLE;
      rd_ch     <= '0;
      rd_idx    <= '0;
      wr_count  <= '0;
      dma_valid <= 1'b0;
      dma_last  <= 1'b0;
    end else if (start) begin
      capture   <= 1'b1;  // also aborts any readout in flight
      read_done <= 1'b0;
      state     <= S_IDLE;
      wr_count  <= '0;
      dma_valid <= 1'b0;
      dma_last  <= 1'b0;
    end else begin
      for (int c = 0; c < rx_pkg::CHANNELS; c++) begin
        if (wr_en[c]) wr_count[c] <= wr_count[c] + 1'b1;
      end
      if (stop && (state == S_IDLE) && !read_done) begin
        capture <= 1'b0;
        state   <= S_COUNT;
        rd_ch   <= '0;
        rd_idx  <= '0;
      end
      if (dma_valid && dma_ready) begin
        dma_valid <= 1'b0;
        dma_last  <= 1'b0;
      end
      if (load) begin
        dma_valid <= 1'b1;
        dma_last  <= rd_last;
        case (state)
          S_TSTAMP: state <= S_DATA;
          default: begin
            if (rd_end_ch) begin
              if (last_ch) begin
                state     <= S_IDLE;  // last word now in output reg
                read_done <= 1'b1;
              end else begin
                rd_ch <= rd_ch + 1'b1;
                state <= S_COUNT;
              end
            end else begin
              // count -> first entry, data -> next entry
              rd_idx <= (state == S_COUNT) ? '0 : rd_idx + 1'b1;
              state  <= S_TSTAMP;
            end
          end
        endcase
      end
    end
  end

  // held until accepted
  always_ff @(posedge clk) begin
    if (load) dma_data <= rd_word;
  end

endmodule

// ==== sample_differentiator.sv ====
`timescale 1ns/1ns
// first difference across the parallel samples of one channel
// last sample of each valid word is history for the next word
module sample_differentiator (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [rx_pkg::WORD_WIDTH-1:0] data,
  input  logic                          valid,
  output logic [rx_pkg::WORD_WIDTH-1:0] diff_data,
  output logic                          diff_valid
);

  logic [rx_pkg::SAMPLE_WIDTH-1:0] last_sample;  // top lane of previous valid word
  logic [rx_pkg::SAMPLE_WIDTH-1:0] prev [rx_pkg::PARALLEL_SAMPLES];  // predecessor per lane
  logic [rx_pkg::WORD_WIDTH-1:0]   diff_next;

  // lane 0 looks back into history, others at the lane below
  always_comb begin
    prev[0] = last_sample;
    for (int i = 1; i < rx_pkg::PARALLEL_SAMPLES; i++) begin
      prev[i] = data[(i-1)*rx_pkg::SAMPLE_WIDTH +: rx_pkg::SAMPLE_WIDTH];
    end
    for (int i = 0; i < rx_pkg::PARALLEL_SAMPLES; i++) begin
      // wraps to sample width
      diff_next[i*rx_pkg::SAMPLE_WIDTH +: rx_pkg::SAMPLE_WIDTH] =
        data[i*rx_pkg::SAMPLE_WIDTH +: rx_pkg::SAMPLE_WIDTH] - prev[i];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_sample <= '0;  // zero history after reset
      diff_valid  <= 1'b0;
    end else begin
      diff_valid <= valid;
      if (valid) begin
        last_sample <= data[rx_pkg::WORD_WIDTH-1 -: rx_pkg::SAMPLE_WIDTH];
      end
    end
  end

  // payload register
  always_ff @(posedge clk) begin
    if (valid) begin
      diff_data <= diff_next;
    end
  end

endmodule

// ==== sample_discriminator.sv ====
`timescale 1ns/1ns
// per-channel threshold test on signed samples
// and per-channel word counters used as timestamps
module sample_discriminator (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic [rx_pkg::CHANNELS-1:0][rx_pkg::WORD_WIDTH-1:0]   data,
  input  logic [rx_pkg::CHANNELS-1:0]                           valid,
  input  logic [rx_pkg::CHANNELS-1:0][rx_pkg::SAMPLE_WIDTH-1:0] config_data,
  input  logic                                                  config_valid,
  input  logic                                                  start,
  output logic [rx_pkg::CHANNELS-1:0][rx_pkg::WORD_WIDTH-1:0]   disc_data,
  output logic [rx_pkg::CHANNELS-1:0]                           disc_valid,
  output logic [rx_pkg::CHANNELS-1:0]                           disc_keep,
  output logic [rx_pkg::CHANNELS-1:0][rx_pkg::TSTAMP_WIDTH-1:0] disc_tstamp
);

  logic [rx_pkg::CHANNELS-1:0][rx_pkg::SAMPLE_WIDTH-1:0] threshold;
  logic [rx_pkg::CHANNELS-1:0][rx_pkg::TSTAMP_WIDTH-1:0] count;       // valid words since start
  logic [rx_pkg::CHANNELS-1:0][rx_pkg::TSTAMP_WIDTH-1:0] count_base;  // count with start applied
  logic [rx_pkg::CHANNELS-1:0]                           keep;

  always_comb begin
    for (int c = 0; c < rx_pkg::CHANNELS; c++) begin
      // a word arriving with start gets timestamp 0
      count_base[c] = start ? '0 : count[c];
      keep[c] = 1'b0;
      for (int i = 0; i < rx_pkg::PARALLEL_SAMPLES; i++) begin
        // any sample strictly above threshold keeps the word
        if ($signed(data[c][i*rx_pkg::SAMPLE_WIDTH +: rx_pkg::SAMPLE_WIDTH]) >
            $signed(threshold[c])) begin
          keep[c] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int c = 0; c < rx_pkg::CHANNELS; c++) begin
        threshold[c] <= {1'b1, {(rx_pkg::SAMPLE_WIDTH-1){1'b0}}};  // most negative value
      end
      count      <= '0;
      disc_valid <= '0;
    end else begin
      if (config_valid) threshold <= config_data;
      disc_valid <= valid;
      for (int c = 0; c < rx_pkg::CHANNELS; c++) begin
        count[c] <= valid[c] ? count_base[c] + 1'b1 : count_base[c];
      end
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    disc_data   <= data;
    disc_keep   <= keep;
    disc_tstamp <= count_base;  // value before the advance
  end

endmodule

// ==== tb_util.svh ====
// testbench helpers: LFSR bit source, value check task
// reference model for differentiator, keep rule and readout order
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// galois LFSR, one step per bit taken
function automatic logic [31:0] take_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    r = {r[30:0], lfsr_state[0]};
    lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
  end
  return r;
endfunction

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("ERROR %s: got %h expected %h", name, got, exp);
  end
endtask

// each sample minus the one before it in time, wraps to sample width
function automatic logic [rx_pkg::WORD_WIDTH-1:0] diff_ref(
  input logic [rx_pkg::PARALLEL_SAMPLES-1:0][rx_pkg::SAMPLE_WIDTH-1:0] w,
  input logic [rx_pkg::SAMPLE_WIDTH-1:0]                               prev
);
  logic [rx_pkg::PARALLEL_SAMPLES-1:0][rx_pkg::SAMPLE_WIDTH-1:0] d;
  d[0] = w[0] - prev;  // prev is top sample of the last valid word
  for (int i = 1; i < rx_pkg::PARALLEL_SAMPLES; i++) begin
    d[i] = w[i] - w[i-1];
  end
  return d;
endfunction

// kept if any signed sample is strictly above threshold
function automatic bit keep_ref(
  input logic [rx_pkg::PARALLEL_SAMPLES-1:0][rx_pkg::SAMPLE_WIDTH-1:0] w,
  input logic [rx_pkg::SAMPLE_WIDTH-1:0]                               thr
);
  bit k;
  k = 1'b0;
  for (int i = 0; i < rx_pkg::PARALLEL_SAMPLES; i++) begin
    if ($signed(w[i]) > $signed(thr)) k = 1'b1;
  end
  return k;
endfunction

// runs the driven words through the model and lists the expected readout
function automatic void build_expected();
  logic [rx_pkg::WORD_WIDTH-1:0]   kept_data [rx_pkg::CHANNELS][rx_pkg::BUFFER_DEPTH];
  logic [rx_pkg::TSTAMP_WIDTH-1:0] kept_ts   [rx_pkg::CHANNELS][rx_pkg::BUFFER_DEPTH];
  int                              n_kept    [rx_pkg::CHANNELS];
  int                              n_valid   [rx_pkg::CHANNELS];  // timestamp source
  logic [rx_pkg::WORD_WIDTH-1:0]   w;
  int                              p;
  n_kept = '{default: 0};
  n_valid = '{default: 0};
  exp_words.delete();
  foreach (drv_data[k]) begin
    for (int c = 0; c < rx_pkg::CHANNELS; c++) begin
      p = sel_cfg[c] % rx_pkg::CHANNELS;  // physical source of logical c
      if (drv_valid[k][p]) begin
        w = (sel_cfg[c] >= rx_pkg::CHANNELS) ? diff_ref(drv_data[k][p], hist[p])
                                             : drv_data[k][p];
        if (keep_ref(w, thr_cfg[c]) && n_kept[c] < rx_pkg::BUFFER_DEPTH) begin
          kept_data[c][n_kept[c]] = w;
          kept_ts[c][n_kept[c]] = n_valid[c];
          n_kept[c]++;
        end
        n_valid[c]++;
      end
    end
    for (int q = 0; q < rx_pkg::CHANNELS; q++) begin  // history after all lanes used it
      if (drv_valid[k][q]) hist[q] = drv_data[k][q][rx_pkg::WORD_WIDTH-1 -: rx_pkg::SAMPLE_WIDTH];
    end
  end
  drv_data.delete();
  drv_valid.delete();
  for (int c = 0; c < rx_pkg::CHANNELS; c++) begin
    exp_words.push_back(n_kept[c]);  // count first, then pairs
    for (int i = 0; i < n_kept[c]; i++) begin
      exp_words.push_back(kept_ts[c][i]);
      exp_words.push_back(kept_data[c][i]);
    end
  end
endfunction

`endif

// ==== tb_receive_top.sv ====
`timescale 1ns/1ns
// testbench for receive_top: clock, reset, stimulus, readout monitor
// and six tests compared against the reference model
module tb_receive_top;

  localparam int READ_TIMEOUT = 3000;  // cycles allowed per readout

  logic clk = 1'b0;
  logic rst_n;
  logic [rx_pkg::CHANNELS-1:0][rx_pkg::WORD_WIDTH-1:0]   adc_data;
  logic [rx_pkg::CHANNELS-1:0]                           adc_valid;
  logic [rx_pkg::CHANNELS-1:0][rx_pkg::SEL_WIDTH-1:0]    mux_config_data;
  logic                                                  mux_config_valid;
  logic [rx_pkg::CHANNELS-1:0][rx_pkg::SAMPLE_WIDTH-1:0] disc_config_data;
  logic                                                  disc_config_valid;
  logic [1:0]                                            buffer_config_data;
  logic                                                  buffer_config_valid;
  logic [rx_pkg::WORD_WIDTH-1:0]                         dma_data;
  logic                                                  dma_valid;
  logic                                                  dma_ready;
  logic                                                  dma_last;

  logic [31:0] lfsr_state = 32'hada2da23;
  logic [rx_pkg::CHANNELS-1:0][rx_pkg::WORD_WIDTH-1:0]   drv_data [$];  // since last readout
  logic [rx_pkg::CHANNELS-1:0]                           drv_valid [$];
  logic [rx_pkg::CHANNELS-1:0][rx_pkg::SEL_WIDTH-1:0]    sel_cfg;  // mirror of DUT config
  logic [rx_pkg::CHANNELS-1:0][rx_pkg::SAMPLE_WIDTH-1:0] thr_cfg;
  logic [rx_pkg::SAMPLE_WIDTH-1:0]                       hist [rx_pkg::CHANNELS];
  logic [rx_pkg::WORD_WIDTH-1:0]                         exp_words [$];
  logic [rx_pkg::WORD_WIDTH:0]                           got_words [$];  // {last, data}
  int last_count = 0;
  int errors = 0;
  int flow_errors = 0;  // timeouts, wrong lengths
  int checks = 0;
  int tests = 0;
  int failed = 0;

  `include "tb_util.svh"

  receive_top dut_i (.*);

  always #4 clk = ~clk;  // 8 ns

  // monitor, every accepted readout word
  always @(posedge clk) begin
    if (rst_n && dma_valid && dma_ready) begin
      got_words.push_back({dma_last, dma_data});
      if (dma_last) last_count <= last_count + 1;
    end
  end

  task automatic set_config(input logic [rx_pkg::CHANNELS-1:0][rx_pkg::SEL_WIDTH-1:0] sel,
                            input logic [rx_pkg::CHANNELS-1:0][rx_pkg::SAMPLE_WIDTH-1:0] thr);
    sel_cfg = sel;
    thr_cfg = thr;
    @(posedge clk);
    mux_config_data   <= sel;
    mux_config_valid  <= 1'b1;
    disc_config_data  <= thr;
    disc_config_valid <= 1'b1;
    @(posedge clk);
    mux_config_valid  <= 1'b0;
    disc_config_valid <= 1'b0;
  endtask

  task automatic command(input logic [1:0] bits);
    @(posedge clk);
    buffer_config_data  <= bits;
    buffer_config_valid <= 1'b1;  // one-cycle pulse
    @(posedge clk);
    buffer_config_valid <= 1'b0;
  endtask

  task automatic send_burst(input int n, input bit gaps);
    logic [rx_pkg::CHANNELS-1:0][rx_pkg::WORD_WIDTH-1:0] d;
    logic [31:0]                                         v;
    for (int k = 0; k < n; k++) begin
      for (int c = 0; c < rx_pkg::CHANNELS; c++) d[c] = take_bits(32);
      v = gaps ? take_bits(2) : 32'h3;  // random valid pattern per channel
      @(posedge clk);
      adc_data  <= d;
      adc_valid <= v[rx_pkg::CHANNELS-1:0];
      drv_data.push_back(d);
      drv_valid.push_back(v[rx_pkg::CHANNELS-1:0]);
    end
    @(posedge clk);
    adc_valid <= '0;
  endtask

  task automatic read_and_check(input bit stall);
    int                          base;
    int                          lasts;
    int                          n;
    int                          cycles;
    logic [31:0]                 ready_bits;
    logic [rx_pkg::WORD_WIDTH:0] g;
    build_expected();
    base = got_words.size();
    lasts = last_count;
    command(2'(1 << rx_pkg::CMD_STOP));
    cycles = 0;
    while (last_count == lasts && cycles < READ_TIMEOUT) begin
      @(posedge clk);
      if (stall) begin
        ready_bits = take_bits(1);
        dma_ready <= ready_bits[0];  // random back-pressure
      end
      @(negedge clk);
      cycles++;
    end
    @(posedge clk);
    dma_ready <= 1'b1;
    if (last_count == lasts) begin
      flow_errors++;
      $display("timeout: readout did not end with dma_last within %0d cycles", READ_TIMEOUT);
      finish_run();
    end else begin
      n = got_words.size() - base;
      if (n != exp_words.size()) begin
        flow_errors++;
        $display("readout length wrong: %0d words received, %0d expected", n, exp_words.size());
      end
      for (int i = 0; i < n && i < exp_words.size(); i++) begin
        g = got_words[base + i];
        check("dma_data", g[rx_pkg::WORD_WIDTH-1:0], exp_words[i]);
        check("dma_last", 32'(g[rx_pkg::WORD_WIDTH]), 32'(i == exp_words.size() - 1));
      end
    end
  endtask

  task automatic report_test(input int num, input string name, input int e0);
    tests++;
    if (errors + flow_errors == e0) begin
      $display("test %0d %s: pass", num, name);
    end else begin
      failed++;
      $display("test %0d %s: FAIL", num, name);
    end
  endtask

  task automatic run_test(input int num, input string name,
                          input logic [rx_pkg::CHANNELS-1:0][rx_pkg::SEL_WIDTH-1:0] sel,
                          input logic [rx_pkg::CHANNELS-1:0][rx_pkg::SAMPLE_WIDTH-1:0] thr,
                          input int n_words, input bit gaps, input bit stall);
    int e0;
    e0 = errors + flow_errors;
    set_config(sel, thr);
    command(2'(1 << rx_pkg::CMD_START));
    send_burst(n_words, gaps);
    repeat (6) @(posedge clk);  // drain the 3-cycle pipeline
    read_and_check(stall);
    report_test(num, name, e0);
  endtask

  task automatic finish_run();
    $display("tests %0d, failed %0d, checks %0d, mismatches %0d, other failures %0d",
             tests, failed, checks, errors, flow_errors);
    if (errors + flow_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  initial begin
    int e0;
    rst_n               <= 1'b0;
    adc_data            <= '0;
    adc_valid           <= '0;
    mux_config_data     <= '0;
    mux_config_valid    <= 1'b0;
    disc_config_data    <= '0;
    disc_config_valid   <= 1'b0;
    buffer_config_data  <= '0;
    buffer_config_valid <= 1'b0;
    dma_ready           <= 1'b1;
    sel_cfg = 4'h4;           // reset selects, raw c on logical c
    thr_cfg = {2{16'h8000}};  // reset thresholds, most negative
    hist = '{default: '0};
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    e0 = errors + flow_errors;
    check("dma_valid", 32'(dma_valid), 32'd0);
    check("dma_last", 32'(dma_last), 32'd0);
    read_and_check(1'b0);  // stop with no start, both counts zero
    report_test(1, "reset state and empty readout", e0);
    run_test(2, "raw burst", 4'h4, {2{16'h8000}}, 40, 1'b0, 1'b0);
    run_test(3, "differentiated with gaps", 4'hE, {2{16'h8000}}, 40, 1'b1, 1'b0);
    run_test(4, "per-channel thresholds", 4'h4, {16'h0000, 16'h4E20}, 50, 1'b0, 1'b0);
    run_test(5, "swapped selects", 4'h1, {2{16'h8000}}, 30, 1'b1, 1'b0);
    run_test(6, "full buffers with stalls", 4'hC, {2{16'h8000}}, 90, 1'b0, 1'b1);
    finish_run();
  end

endmodule
